// File: hw/isaPkg.sv
// ISA definitions for the 16-bit single-cycle processor
//   word and register index types
//   opcode enum taken from instruction bits 15..11
//   register field positions
package isaPkg;

   parameter int wordBits   = 16;
   parameter int regIdxBits = 3;

   typedef logic [wordBits-1:0]   wordT;
   typedef logic [regIdxBits-1:0] regIdxT;

   // Opcode field sits at the top of the word
   parameter int opLsb = 11;

   // Register fields
   //   R-type   op | rd | rs | rt | xx
   //   ADDI/LD  op | rd | rs | imm5
   //   ST       op | rt | rs | imm5   (store data in the rd slot)
   //   LI       op | rd | imm8
   //   BEQZ/NEZ op | rs | imm8        (tested reg in the rd slot)
   //   J        op | imm11
   parameter int rdLsb = 8;
   parameter int rsLsb = 5;
   parameter int rtLsb = 2;

   typedef enum logic [4:0] {
      opHalt = 5'h00,  // Zeroed memory stops the core
      opNop  = 5'h01,
      opAdd  = 5'h02,
      opSub  = 5'h03,
      opAnd  = 5'h04,
      opXor  = 5'h05,
      opSeq  = 5'h06,
      opSlt  = 5'h07,
      opAddi = 5'h08,
      opLi   = 5'h09,
      opLd   = 5'h0a,
      opSt   = 5'h0b,
      opBeqz = 5'h0c,
      opBnez = 5'h0d,
      opJ    = 5'h0e
      // 5'h0f..5'h1f are illegal
   } opcodeE;

endpackage

// File: hw/ctrlPkg.sv
// Datapath control definitions
//   ALU operation and source select enums
//   control bundle from decode
//   per-cycle retire record
package ctrlPkg;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluXor,
      aluPassB  // LI
   } aluOpE;

   typedef enum logic [1:0] {
      srcRt,
      srcImm5,
      srcImm8
   } srcBE;

   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbSet
   } wbSrcE;

   typedef struct packed {
      aluOpE aluOp;
      srcBE  srcB;
      wbSrcE wbSrc;
      logic  regWrite;
      logic  memWrite;
      logic  branchZero;
      logic  branchNonZero;
      logic  jump;
      logic  setEq;
      logic  setLt;
      logic  halt;
      logic  illegal;   // Undefined opcode, all writes off
   } ctrlT;

   typedef struct packed {
      logic           valid;
      isaPkg::wordT   pc;
      logic           regWrite;
      isaPkg::regIdxT rd;
      isaPkg::wordT   wdata;
      logic           memWrite;
      isaPkg::wordT   memAddr;
      isaPkg::wordT   memData;
   } retireT;

endpackage

// File: hw/fetch.sv
// Fetch stage
//   PC register with halt hold
//   word-indexed instruction memory, async read
//   program-load write port
`timescale 1ns/1ps

module fetch #(
   parameter int ImemAddrBits = 8
) (
   input  logic                    clk,
   input  logic                    arstN,
   input  logic                    stop,      // HALT or illegal this cycle
   input  isaPkg::wordT            pcNext,
   input  logic                    progWe,
   input  logic [ImemAddrBits-1:0] progAddr,
   input  isaPkg::wordT            progData,
   output isaPkg::wordT            instr,
   output isaPkg::wordT            pc,
   output isaPkg::wordT            pcPlusTwo,
   output logic                    halted
);
   import isaPkg::*;

   localparam int ImemWords = 2 ** ImemAddrBits;

   wordT imem [ImemWords];

   // Load port is live regardless of reset
   always_ff @(posedge clk) begin
      if (progWe)
         imem[progAddr] <= progData;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (!halted) begin
         if (stop)
            halted <= 1'b1;  // PC freezes on the stopping instruction
         else
            pc <= pcNext;
      end
   end

   assign instr     = imem[pc[ImemAddrBits:1]];  // Word index
   assign pcPlusTwo = pc + wordT'(2);

endmodule

// File: hw/decode.sv
// Decode stage
//   opcode to control bundle, illegal opcode flag
//   eight-entry register file, cleared on reset
//   immediate select and sign extension
`timescale 1ns/1ps

module decode (
   input  logic           clk,
   input  logic           arstN,
   input  isaPkg::wordT   instr,
   input  isaPkg::wordT   wdata,
   input  logic           halted,
   output ctrlPkg::ctrlT  ctrl,
   output isaPkg::wordT   rsData,
   output isaPkg::wordT   rtData,
   output isaPkg::wordT   imm,
   output isaPkg::regIdxT rd
);
   import isaPkg::*;
   import ctrlPkg::*;

   opcodeE opcode;
   regIdxT rsAddr, rtAddr;
   wordT   regs [2**regIdxBits];
   wordT   imm5Ext, imm8Ext, imm11Ext;

   assign opcode = opcodeE'(instr[wordBits-1:opLsb]);
   assign rd     = instr[rdLsb +: regIdxBits];

   // Branches test the register in the rd slot, ST stores it
   always_comb begin
      rsAddr = instr[rsLsb +: regIdxBits];
      rtAddr = instr[rtLsb +: regIdxBits];
      if (opcode == opBeqz || opcode == opBnez)
         rsAddr = rd;
      if (opcode == opSt)
         rtAddr = rd;
   end

   always_comb begin
      ctrl       = '0;
      ctrl.aluOp = aluAdd;
      ctrl.srcB  = srcRt;
      ctrl.wbSrc = wbAlu;
      case (opcode)
         opAdd: ctrl.regWrite = 1'b1;
         opSub: begin
            ctrl.aluOp    = aluSub;
            ctrl.regWrite = 1'b1;
         end
         opAnd: begin
            ctrl.aluOp    = aluAnd;
            ctrl.regWrite = 1'b1;
         end
         opXor: begin
            ctrl.aluOp    = aluXor;
            ctrl.regWrite = 1'b1;
         end
         opSeq: begin
            ctrl.setEq    = 1'b1;
            ctrl.wbSrc    = wbSet;
            ctrl.regWrite = 1'b1;
         end
         opSlt: begin
            ctrl.setLt    = 1'b1;
            ctrl.wbSrc    = wbSet;
            ctrl.regWrite = 1'b1;
         end
         opAddi: begin
            ctrl.srcB     = srcImm5;
            ctrl.regWrite = 1'b1;
         end
         opLi: begin
            ctrl.aluOp    = aluPassB;
            ctrl.srcB     = srcImm8;
            ctrl.regWrite = 1'b1;
         end
         opLd: begin
            ctrl.srcB     = srcImm5;  // Address is rs + imm5
            ctrl.wbSrc    = wbMem;
            ctrl.regWrite = 1'b1;
         end
         opSt: begin
            ctrl.srcB     = srcImm5;
            ctrl.memWrite = 1'b1;
         end
         opBeqz: ctrl.branchZero    = 1'b1;
         opBnez: ctrl.branchNonZero = 1'b1;
         opJ:    ctrl.jump          = 1'b1;
         opHalt: ctrl.halt          = 1'b1;
         opNop:  ;
         default: ctrl.illegal = 1'b1;
      endcase
   end

   assign imm5Ext  = {{(wordBits-5){instr[4]}}, instr[4:0]};
   assign imm8Ext  = {{(wordBits-8){instr[7]}}, instr[7:0]};
   assign imm11Ext = {{(wordBits-11){instr[10]}}, instr[10:0]};

   always_comb begin
      case (opcode)
         opLi, opBeqz, opBnez: imm = imm8Ext;
         opJ:                  imm = imm11Ext;
         default:              imm = imm5Ext;
      endcase
   end

   // Register file, r0 is an ordinary register
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 2**regIdxBits; i++)
            regs[i] <= '0;
      end else if (ctrl.regWrite && !halted) begin
         regs[rd] <= wdata;
      end
   end

   assign rsData = regs[rsAddr];
   assign rtData = regs[rtAddr];

endmodule

// File: hw/execution.sv
// Execute stage
//   ALU with operand B select
//   SEQ / SLT condition results
//   branch and jump targets, next-PC select
`timescale 1ns/1ps

module execution (
   input  ctrlPkg::ctrlT ctrl,
   input  isaPkg::wordT  rsData,
   input  isaPkg::wordT  rtData,
   input  isaPkg::wordT  imm,
   input  isaPkg::wordT  pc,
   input  isaPkg::wordT  pcPlusTwo,
   output isaPkg::wordT  aluOut,
   output isaPkg::wordT  setOut,
   output isaPkg::wordT  pcNext
);
   import isaPkg::*;
   import ctrlPkg::*;

   wordT opB;
   wordT target;
   logic condSet;
   logic taken;

   always_comb begin
      case (ctrl.srcB)
         srcImm5, srcImm8: opB = imm;  // Already extended in decode
         default:          opB = rtData;
      endcase
   end

   always_comb begin
      case (ctrl.aluOp)
         aluSub:   aluOut = rsData - opB;
         aluAnd:   aluOut = rsData & opB;
         aluXor:   aluOut = rsData ^ opB;
         aluPassB: aluOut = opB;
         default:  aluOut = rsData + opB;
      endcase
   end

   // Signed compare for SLT
   always_comb begin
      condSet = 1'b0;
      if (ctrl.setEq)
         condSet = (rsData == rtData);
      else if (ctrl.setLt)
         condSet = ($signed(rsData) < $signed(rtData));
   end

   assign setOut = {{(wordBits-1){1'b0}}, condSet};

   assign taken = (ctrl.branchZero    && rsData == '0) ||
                  (ctrl.branchNonZero && rsData != '0);

   // Offsets count words
   assign target = pcPlusTwo + {imm[wordBits-2:0], 1'b0};

   always_comb begin
      if (ctrl.halt || ctrl.illegal)
         pcNext = pc;  // Hold on stop
      else if (ctrl.jump || taken)
         pcNext = target;
      else
         pcNext = pcPlusTwo;
   end

endmodule

// File: hw/memory.sv
// Memory stage
//   word-indexed data memory, cleared on reset
//   async read, store on the clock edge
//   write-back result select
`timescale 1ns/1ps

module memory #(
   parameter int DmemAddrBits = 8
) (
   input  logic          clk,
   input  logic          arstN,
   input  ctrlPkg::ctrlT ctrl,
   input  logic          halted,
   input  isaPkg::wordT  aluOut,
   input  isaPkg::wordT  rtData,
   input  isaPkg::wordT  setOut,
   output isaPkg::wordT  wdata
);
   import isaPkg::*;
   import ctrlPkg::*;

   localparam int DmemWords = 2 ** DmemAddrBits;

   logic [DmemAddrBits-1:0] addr;
   wordT                    dmem [DmemWords];

   assign addr = aluOut[DmemAddrBits:1];  // Byte address to word index

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < DmemWords; i++)
            dmem[i] <= '0;
      end else if (ctrl.memWrite && !halted) begin
         dmem[addr] <= rtData;
      end
   end

   always_comb begin
      case (ctrl.wbSrc)
         wbMem:   wdata = dmem[addr];
         wbSet:   wdata = setOut;
         default: wdata = aluOut;
      endcase
   end

endmodule

// File: hw/proc.sv
// Processor top level
//   fetch, decode, execution and memory stages
//   sticky error flag for illegal opcodes
//   retire record of the current instruction
`timescale 1ns/1ps

module proc #(
   parameter int ImemAddrBits = 8,
   parameter int DmemAddrBits = 8
) (
   input  logic                    clk,
   input  logic                    arstN,
   input  logic                    progWe,
   input  logic [ImemAddrBits-1:0] progAddr,
   input  isaPkg::wordT            progData,
   output logic                    err,
   output logic                    halted,
   output ctrlPkg::retireT         retire
);
   import isaPkg::*;
   import ctrlPkg::*;

   wordT   instr, pc, pcPlusTwo, pcNext;
   wordT   rsData, rtData, imm;
   wordT   aluOut, setOut, wdata;
   regIdxT rd;
   ctrlT   ctrl;
   logic   stop;

   assign stop = ctrl.halt | ctrl.illegal;

   fetch #(.ImemAddrBits(ImemAddrBits)) fetch0 (
      .clk       (clk),
      .arstN     (arstN),
      .stop      (stop),
      .pcNext    (pcNext),
      .progWe    (progWe),
      .progAddr  (progAddr),
      .progData  (progData),
      .instr     (instr),
      .pc        (pc),
      .pcPlusTwo (pcPlusTwo),
      .halted    (halted)
   );

   decode decode0 (
      .clk    (clk),
      .arstN  (arstN),
      .instr  (instr),
      .wdata  (wdata),     // From the write-back select in memory
      .halted (halted),
      .ctrl   (ctrl),
      .rsData (rsData),
      .rtData (rtData),
      .imm    (imm),
      .rd     (rd)
   );

   execution exec0 (
      .ctrl      (ctrl),
      .rsData    (rsData),
      .rtData    (rtData),
      .imm       (imm),
      .pc        (pc),
      .pcPlusTwo (pcPlusTwo),
      .aluOut    (aluOut),
      .setOut    (setOut),
      .pcNext    (pcNext)
   );

   memory #(.DmemAddrBits(DmemAddrBits)) memory0 (
      .clk    (clk),
      .arstN  (arstN),
      .ctrl   (ctrl),
      .halted (halted),
      .aluOut (aluOut),    // Address
      .rtData (rtData),    // Store data
      .setOut (setOut),
      .wdata  (wdata)
   );

   // Set with the halt on an illegal opcode, cleared only by reset
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN)
         err <= 1'b0;
      else if (ctrl.illegal && !halted)
         err <= 1'b1;
   end

   always_comb begin
      retire.valid    = arstN && !halted;  // Nothing retires while held in reset
      retire.pc       = pc;
      retire.regWrite = ctrl.regWrite;
      retire.rd       = rd;
      retire.wdata    = wdata;
      retire.memWrite = ctrl.memWrite;
      retire.memAddr  = aluOut;
      retire.memData  = rtData;
   end

endmodule

// File: tb/procModel.svh
// ISA reference model for the processor testbench
//   architectural registers, data memory and PC
//   sign extension of instruction immediates
//   one step per retired instruction, giving the expected retire record

wordT modelRegs [8];
wordT modelDmem [2**DmemAddrBits];
wordT modelPc;

function automatic wordT signExtend(input wordT value, input int bits);
   wordT sign;
   sign = wordT'(1) << (bits - 1);
   value = value & ((sign << 1) - wordT'(1));  // Keep the field only
   return (value ^ sign) - sign;
endfunction

task automatic modelReset();
   modelPc = '0;
   for (int i = 0; i < 8; i++)
      modelRegs[i] = '0;
   for (int i = 0; i < 2**DmemAddrBits; i++)
      modelDmem[i] = '0;
endtask

// Expected record for the instruction at modelPc, then the state update
task automatic modelStep(input wordT ins, output retireT exp, output logic stopped);
   opcodeE op;
   regIdxT rd, rs, rt;
   wordT   a, res, addr, nextPc;
   logic   wr;
   op     = opcodeE'(ins[15:11]);
   rd     = ins[10:8];
   rs     = ins[7:5];
   rt     = ins[4:2];
   a      = modelRegs[rs];
   addr   = a + signExtend(ins, 5);
   res    = '0;
   wr     = 1'b1;
   stopped = 1'b0;
   nextPc = modelPc + wordT'(2);
   exp    = '0;
   exp.valid = 1'b1;
   exp.pc    = modelPc;
   exp.rd    = rd;
   case (op)
      opAdd:  res = a + modelRegs[rt];
      opSub:  res = a - modelRegs[rt];
      opAnd:  res = a & modelRegs[rt];
      opXor:  res = a ^ modelRegs[rt];
      opSeq:  res = wordT'(a == modelRegs[rt]);
      opSlt:  res = wordT'($signed(a) < $signed(modelRegs[rt]));
      opAddi: res = addr;
      opLi:   res = signExtend(ins, 8);
      opLd:   res = modelDmem[addr[DmemAddrBits:1]];  // Word index
      opSt: begin
         wr = 1'b0;
         exp.memWrite = 1'b1;
         exp.memAddr  = addr;
         exp.memData  = modelRegs[rd];  // Data register sits in the rd slot
         modelDmem[addr[DmemAddrBits:1]] = modelRegs[rd];
      end
      opBeqz, opBnez: begin
         wr = 1'b0;
         if ((modelRegs[rd] == '0) == (op == opBeqz))
            nextPc = nextPc + (signExtend(ins, 8) << 1);
      end
      opJ: begin
         wr = 1'b0;
         nextPc = nextPc + (signExtend(ins, 11) << 1);
      end
      opNop:  wr = 1'b0;
      default: begin  // HALT and undefined codes
         wr      = 1'b0;
         stopped = 1'b1;
         nextPc  = modelPc;
      end
   endcase
   if (wr) begin
      exp.regWrite  = 1'b1;
      exp.wdata     = res;
      modelRegs[rd] = res;
   end
   modelPc = nextPc;
endtask

// File: tb/procTb.sv
// Testbench for the single-cycle processor
//   clock, reset and program load through the load port
//   random programs from an LCG, checked against the ISA model
//   HALT hold, illegal opcode and recovery after reset
`timescale 1ns/1ps

module procTb;
   import isaPkg::*;
   import ctrlPkg::*;

   localparam int ImemAddrBits = 8;
   localparam int DmemAddrBits = 8;
   localparam int ProgLen      = 40;  // Instructions before the final HALT
   localparam int NumPrograms  = 6;
   localparam int NumTests     = NumPrograms + 2;
   // Load, run and the HALT hold for each test, plus margin
   localparam int CycleLimit   = NumTests * (2 * ProgLen + 40) + 100;
   localparam opcodeE ROps [6] = '{opAdd, opSub, opAnd, opXor, opSeq, opSlt};

   logic                    clk;
   logic                    arstN;
   logic                    progWe;
   logic [ImemAddrBits-1:0] progAddr;
   wordT                    progData;
   logic                    err;
   logic                    halted;
   retireT                  retire;

   wordT        prog [2**ImemAddrBits];
   int          progLen;
   int unsigned lcgState;
   int          errorCount;
   int          passedTests;
   int          failedTests;
   int          cycleCount;

   `include "procModel.svh"

   proc #(.ImemAddrBits(ImemAddrBits), .DmemAddrBits(DmemAddrBits)) i_proc (
      .clk      (clk),
      .arstN    (arstN),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .err      (err),
      .halted   (halted),
      .retire   (retire)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount == CycleLimit) begin
         $display("Run stopped, no end of tests after %0d cycles", cycleCount);
         $display("tests failed");
         $finish;
      end
   end

   function automatic int unsigned randBelow(input int unsigned n);
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return (lcgState >> 16) % n;
   endfunction

   function automatic string showRetire(input retireT r);
      return $sformatf("v%b pc %h w%b r%0d %h st%b %h %h", r.valid, r.pc, r.regWrite,
                       r.rd, r.wdata, r.memWrite, r.memAddr, r.memData);
   endfunction

   // Fields that the instruction does not write are not compared
   task automatic checkRetire(input string name, input retireT exp, input retireT act);
      retireT masked;
      masked = act;
      if (!exp.regWrite) begin
         masked.rd    = exp.rd;
         masked.wdata = exp.wdata;
      end
      if (!exp.memWrite) begin
         masked.memAddr = exp.memAddr;
         masked.memData = exp.memData;
      end
      if (masked !== exp) begin
         errorCount++;
         $display("[FAIL] %s expected %s actual %s", name, showRetire(exp), showRetire(act));
      end
   endtask

   task automatic checkWord(input string name, input wordT exp, input wordT act);
      if (act !== exp) begin
         errorCount++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic checkFlag(input string name, input bit exp, input logic act);
      if (act !== exp) begin
         errorCount++;
         $display("[FAIL] %s expected %b actual %b", name, exp, act);
      end
   endtask

   // r6 and r7 hold the load/store bases, random writes go to r0..r5
   task automatic makeProgram(input bit withIllegal);
      int     stopIdx;
      int     kind;
      regIdxT rd, rs, rt, base;
      logic [4:0] imm5;
      stopIdx = withIllegal ? 2 + int'(randBelow(ProgLen - 2)) : ProgLen;
      prog[0] = {opLi, 3'd6, 8'(randBelow(64))};
      prog[1] = {opLi, 3'd7, 8'(randBelow(64))};
      for (int i = 2; i < stopIdx; i++) begin
         kind = int'(randBelow(14));
         rd   = 3'(randBelow(6));
         rs   = 3'(randBelow(8));
         rt   = 3'(randBelow(8));
         base = 3'(6 + randBelow(2));
         imm5 = 5'(randBelow(32));
         case (kind)
            6:  prog[i] = {opAddi, rd, rs, imm5};
            7:  prog[i] = {opLi, rd, 8'(randBelow(256))};
            8:  prog[i] = {opLd, rd, base, imm5};
            9:  prog[i] = {opSt, rs, base, imm5};
            10: prog[i] = {opBeqz, rs, 8'(randBelow(stopIdx - i))};  // Forward, in range
            11: prog[i] = {opBnez, rs, 8'(randBelow(stopIdx - i))};
            12: prog[i] = {opJ, 11'(randBelow(stopIdx - i))};
            13: prog[i] = {opNop, 11'(randBelow(2048))};
            default: prog[i] = {ROps[kind], rd, rs, rt, 2'b00};
         endcase
      end
      if (withIllegal)
         prog[stopIdx] = {5'(15 + randBelow(17)), 11'(randBelow(2048))};
      else
         prog[stopIdx] = {opHalt, 11'd0};
      progLen = stopIdx + 1;
   endtask

   task automatic loadWithReset(input string name);
      int holdCycles;
      holdCycles = (progLen > 5) ? progLen : 5;
      @(posedge clk);
      arstN <= 1'b0;
      for (int i = 0; i < holdCycles; i++) begin
         @(posedge clk);
         progWe   <= (i < progLen);
         progAddr <= ImemAddrBits'(i);
         progData <= prog[i];
      end
      @(negedge clk);
      checkFlag({name, " err in reset"}, 1'b0, err);
      checkFlag({name, " halted in reset"}, 1'b0, halted);
      checkFlag({name, " retire valid in reset"}, 1'b0, retire.valid);
      @(posedge clk);
      progWe <= 1'b0;
      arstN  <= 1'b1;
   endtask

   task automatic runTest(input string name, input bit withIllegal);
      retireT exp;
      logic   stopped;
      int     errsBefore;
      errsBefore = errorCount;
      makeProgram(withIllegal);
      loadWithReset(name);
      modelReset();
      stopped = 1'b0;
      while (!stopped) begin
         @(negedge clk);
         modelStep(prog[modelPc[ImemAddrBits:1]], exp, stopped);
         checkRetire($sformatf("%s at pc %h", name, exp.pc), exp, retire);
      end
      // Stopped core holds for 10 cycles
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         checkFlag({name, " halted"}, 1'b1, halted);
         checkFlag({name, " err"}, withIllegal, err);
         checkFlag({name, " retire valid"}, 1'b0, retire.valid);
         checkWord({name, " held pc"}, exp.pc, retire.pc);
      end
      if (errorCount == errsBefore) begin
         passedTests++;
         $display("test %s: ok", name);
      end else begin
         failedTests++;
         $display("test %s: %0d mismatches", name, errorCount - errsBefore);
      end
   endtask

   initial begin
      clk         = 1'b0;
      arstN       = 1'b0;
      progWe      = 1'b0;
      progAddr    = '0;
      progData    = '0;
      lcgState    = 91;
      errorCount  = 0;
      passedTests = 0;
      failedTests = 0;
      cycleCount  = 0;
      for (int k = 0; k < NumPrograms; k++)
         runTest($sformatf("random program %0d", k), 1'b0);
      runTest("illegal opcode", 1'b1);
      runTest("program after illegal", 1'b0);
      $display("tests: %0d run, %0d passed, %0d failed",
               passedTests + failedTests, passedTests, failedTests);
      if (failedTests == 0 && errorCount == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+tb
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/fetch.sv
hw/decode.sv
hw/execution.sv
hw/memory.sv
hw/proc.sv
tb/procTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module procTb -o procSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/procSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" sim.log; then
   echo "Simulation reported failures"
   exit 1
fi

exit 0
